// ==== include/isqrt_lut.svh ====
// Entry i is 1/sqrt(i/256) in Q8.12 and entry 0 repeats entry 1
localparam isqrt_t ISQRT_LUT [0:LUT_ENTRIES-1] = '{
    20'd65536,
    20'd65536,
    20'd46341,
    20'd37837,
    20'd32768,
    20'd29309,
    20'd26755,
    20'd24770,
    20'd23170,
    20'd21845,
    20'd20724,
    20'd19760,
    20'd18919,
    20'd18176,
    20'd17515,
    20'd16921,
    20'd16384,
    20'd15895,
    20'd15447,
    20'd15035,
    20'd14654,
    20'd14301,
    20'd13972,
    20'd13665,
    20'd13377,
    20'd13107,
    20'd12853,
    20'd12612,
    20'd12385,
    20'd12170,
    20'd11965,
    20'd11771
};

// ==== design/norm_fixed_pkg.sv ====
`default_nettype none

package norm_fixed_pkg;

    // One 2x2 compute tile per beat
    localparam int LANES = 4;

    // Fraction bits of the Q8.12 inverse square root
    localparam int ISQRT_FRAC = 12;
    localparam int LUT_ENTRIES = 32;

    // Output saturation bounds for Q4.4
    localparam int SAMPLE_MAX = 127;
    localparam int SAMPLE_MIN = -128;

    typedef logic signed [7:0]  sample_t;
    typedef logic signed [8:0]  diff_t;
    typedef logic        [17:0] square_t;
    typedef logic signed [15:0] sum_t;
    typedef logic        [31:0] sumsq_t;
    typedef logic        [23:0] var_t;
    typedef logic        [19:0] isqrt_t;

    typedef struct packed {
        sample_t [LANES-1:0] lane;
    } sample_beat_t;

    typedef struct packed {
        diff_t [LANES-1:0] lane;
    } diff_beat_t;

endpackage

`default_nettype wire

// ==== design/norm_ctrl_pkg.sv ====
`default_nettype none

package norm_ctrl_pkg;

    typedef enum logic {
        ACC_RUN,
        ACC_HOLD
    } acc_state_e;

    typedef enum logic [1:0] {
        ISQ_IDLE,
        ISQ_NORMALIZE,
        ISQ_LOOKUP,
        ISQ_HOLD
    } isqrt_state_e;

endpackage

`default_nettype wire

// ==== design/matrix_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_fifo
    import norm_fixed_pkg::*;
#(
    parameter int  DEPTH  = 8,
    parameter type BEAT_T = sample_beat_t
) (
    input  logic  clk,
    input  logic  rst_n,
    input  BEAT_T in_beat,
    input  logic  in_valid,
    output logic  in_ready,
    output BEAT_T out_beat,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    BEAT_T mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_wr;
    logic do_rd;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];
    assign do_wr     = in_valid && in_ready;
    assign do_rd     = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd)
                rd_ptr <= ptr_inc(rd_ptr);
            // Simultaneous read and write leaves the count as is
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= in_beat;
    end

endmodule

`default_nettype wire

// ==== design/lane_reduce_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_reduce_acc
    import norm_fixed_pkg::*;
    import norm_ctrl_pkg::*;
#(
    parameter int GROUP_BEATS = 8,
    parameter int WIDTH       = 8,
    parameter int OUT_WIDTH   = 16,
    parameter bit SIGNED      = 1'b1
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [LANES-1:0][WIDTH-1:0] lanes,
    input  logic                        in_valid,
    output logic                        in_ready,
    output logic [OUT_WIDTH-1:0]        total,
    output logic                        out_valid,
    input  logic                        out_ready
);

    localparam int CNT_W = (GROUP_BEATS > 1) ? $clog2(GROUP_BEATS) : 1;

    acc_state_e state;
    logic [CNT_W-1:0] beat_cnt;
    logic [OUT_WIDTH-1:0] acc;
    logic [LANES-1:0][OUT_WIDTH-1:0] ext;
    logic [OUT_WIDTH-1:0] pair_lo;
    logic [OUT_WIDTH-1:0] pair_hi;
    logic [OUT_WIDTH-1:0] beat_sum;
    logic last_beat;

    // Widen each lane first with sign fill only for signed data
    for (genvar i = 0; i < LANES; i++) begin : g_ext
        assign ext[i] = {{(OUT_WIDTH - WIDTH){SIGNED & lanes[i][WIDTH-1]}}, lanes[i]};
    end

    // Two-level tree over the 2x2 tile
    assign pair_lo  = ext[0] + ext[1];
    assign pair_hi  = ext[2] + ext[3];
    assign beat_sum = pair_lo + pair_hi;

    assign last_beat = (beat_cnt == CNT_W'(GROUP_BEATS - 1));
    assign in_ready  = (state == ACC_RUN);
    assign out_valid = (state == ACC_HOLD);
    assign total     = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ACC_RUN;
            beat_cnt <= '0;
            acc      <= '0;
        end else begin
            case (state)
                ACC_RUN: begin
                    if (in_valid) begin
                        acc <= acc + beat_sum;
                        if (last_beat) begin
                            beat_cnt <= '0;
                            state    <= ACC_HOLD;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                ACC_HOLD: begin
                    // Next group starts from zero once the total is taken
                    if (out_ready) begin
                        acc   <= '0;
                        state <= ACC_RUN;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/repeat_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module repeat_buffer #(
    parameter int GROUP_BEATS = 8,
    parameter int WIDTH       = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int CNT_W = (GROUP_BEATS > 1) ? $clog2(GROUP_BEATS) : 1;

    logic [WIDTH-1:0] data_r;
    logic [CNT_W-1:0] replay_cnt;
    logic full;

    assign in_ready  = !full;
    assign out_valid = full;
    assign out_data  = data_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full       <= 1'b0;
            replay_cnt <= '0;
        end else if (in_valid && in_ready) begin
            full       <= 1'b1;
            replay_cnt <= '0;
        end else if (full && out_ready) begin
            // Free the slot after the last replay of the group
            if (replay_cnt == CNT_W'(GROUP_BEATS - 1)) begin
                full       <= 1'b0;
                replay_cnt <= '0;
            end else begin
                replay_cnt <= replay_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            data_r <= in_data;
    end

endmodule

`default_nettype wire

// ==== design/center_square.sv ====
`timescale 1ns/1ps
`default_nettype none

module center_square
    import norm_fixed_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  sample_beat_t        in_beat,
    input  sample_t             mean,
    input  logic                in_valid,
    output logic                in_ready,
    output diff_beat_t          diff_beat,
    output logic                diff_valid,
    input  logic                diff_ready,
    output square_t [LANES-1:0] squares,
    output logic                sq_valid,
    input  logic                sq_ready
);

    typedef logic signed [2*$bits(diff_t)-1:0] wide_t;

    diff_beat_t diff_next;
    square_t [LANES-1:0] sq_next;
    logic diff_pend;
    logic sq_pend;
    logic take;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            diff_next.lane[i] = diff_t'(in_beat.lane[i]) - diff_t'(mean);
            sq_next[i] = square_t'(wide_t'(diff_next.lane[i]) * wide_t'(diff_next.lane[i]));
        end
    end

    // Stage frees up only when each branch has been handed over
    assign in_ready   = (!diff_pend || diff_ready) && (!sq_pend || sq_ready);
    assign take       = in_valid && in_ready;
    assign diff_valid = diff_pend;
    assign sq_valid   = sq_pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            diff_pend <= 1'b0;
            sq_pend   <= 1'b0;
        end else if (take) begin
            diff_pend <= 1'b1;
            sq_pend   <= 1'b1;
        end else begin
            if (diff_ready)
                diff_pend <= 1'b0;
            if (sq_ready)
                sq_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            diff_beat <= diff_next;
            squares   <= sq_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/inv_sqrt_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module inv_sqrt_unit
    import norm_fixed_pkg::*;
    import norm_ctrl_pkg::*;
#(
    parameter int GROUP_BEATS = 8
) (
    input  logic   clk,
    input  logic   rst_n,
    input  sumsq_t sumsq,
    input  logic   in_valid,
    output logic   in_ready,
    output isqrt_t isqrt,
    output logic   out_valid,
    input  logic   out_ready
);

    `include "isqrt_lut.svh"

    localparam int N = GROUP_BEATS * LANES;
    localparam int IDX_W = $clog2(LUT_ENTRIES);

    isqrt_state_e state;
    var_t var_r;
    logic [3:0] shift_k;
    isqrt_t isqrt_r;
    logic in_range;

    assign in_range  = (var_r < var_t'(LUT_ENTRIES));
    assign in_ready  = (state == ISQ_IDLE);
    assign out_valid = (state == ISQ_HOLD);
    assign isqrt     = isqrt_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ISQ_IDLE;
        end else begin
            case (state)
                ISQ_IDLE: begin
                    if (in_valid)
                        state <= ISQ_NORMALIZE;
                end
                ISQ_NORMALIZE: begin
                    if (in_range)
                        state <= ISQ_LOOKUP;
                end
                ISQ_LOOKUP: begin
                    state <= ISQ_HOLD;
                end
                ISQ_HOLD: begin
                    if (out_ready)
                        state <= ISQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ISQ_IDLE: begin
                if (in_valid) begin
                    var_r   <= var_t'(sumsq / sumsq_t'(N));
                    shift_k <= '0;
                end
            end
            ISQ_NORMALIZE: begin
                // Each even shift halves the square root and k counts the halvings
                if (!in_range) begin
                    var_r   <= var_r >> 2;
                    shift_k <= shift_k + 1'b1;
                end
            end
            ISQ_LOOKUP: begin
                isqrt_r <= ISQRT_LUT[var_r[IDX_W-1:0]] >> shift_k;
            end
            ISQ_HOLD: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/norm_scale_cast.sv ====
`timescale 1ns/1ps
`default_nettype none

module norm_scale_cast
    import norm_fixed_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  diff_beat_t   diff_beat,
    input  isqrt_t       isqrt,
    input  logic         in_valid,
    output logic         in_ready,
    output sample_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    localparam int PROD_W = $bits(diff_t) + $bits(isqrt_t) + 1;

    typedef logic signed [PROD_W-1:0] prod_t;

    sample_beat_t cast_next;
    logic valid_r;

    // Q5.4 times Q8.12 gives 16 fraction bits before the shift back to Q4.4
    function automatic sample_t scale_lane(input diff_t d, input isqrt_t s);
        prod_t prod;
        prod_t floored;
        prod = prod_t'(d) * prod_t'({1'b0, s});
        floored = prod >>> ISQRT_FRAC;
        if (floored > prod_t'(SAMPLE_MAX))
            return sample_t'(SAMPLE_MAX);
        if (floored < prod_t'(SAMPLE_MIN))
            return sample_t'(SAMPLE_MIN);
        return sample_t'(floored);
    endfunction

    always_comb begin
        for (int i = 0; i < LANES; i++)
            cast_next.lane[i] = scale_lane(diff_beat.lane[i], isqrt);
    end

    assign in_ready  = !valid_r || out_ready;
    assign out_valid = valid_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid_r <= 1'b0;
        else if (in_ready)
            valid_r <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            out_beat <= cast_next;
    end

endmodule

`default_nettype wire

// ==== design/group_norm_2d.sv ====
`timescale 1ns/1ps
`default_nettype none

module group_norm_2d
    import norm_fixed_pkg::*;
#(
    parameter int TOTAL_DIM0     = 4,
    parameter int TOTAL_DIM1     = 4,
    parameter int GROUP_CHANNELS = 2
) (
    input  logic         clk,
    input  logic         rst_n,
    input  sample_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output sample_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    localparam int GROUP_BEATS = TOTAL_DIM0 * TOTAL_DIM1 * GROUP_CHANNELS / LANES;
    localparam int N = GROUP_BEATS * LANES;

    sample_beat_t fifo_beat;
    logic fifo_in_valid, fifo_in_ready, fifo_out_valid, fifo_out_ready;
    logic sum_in_valid, sum_in_ready;
    sum_t sum_total;
    logic sum_valid, sum_ready;
    sample_t mean;
    sample_t mean_rep;
    logic mean_rep_valid, mean_rep_ready;
    logic cs_in_valid, cs_in_ready;
    diff_beat_t cs_diff;
    logic cs_diff_valid, cs_diff_ready;
    square_t [LANES-1:0] cs_sq;
    logic cs_sq_valid, cs_sq_ready;
    diff_beat_t dfifo_beat;
    logic dfifo_valid, dfifo_ready;
    sumsq_t sumsq;
    logic sumsq_valid, sumsq_ready;
    isqrt_t isq;
    logic isq_valid, isq_ready;
    isqrt_t isq_rep;
    logic isq_rep_valid, isq_rep_ready;
    logic nsc_in_valid, nsc_in_ready;

    // Both sides of the input fork take the beat together
    assign in_ready      = fifo_in_ready && sum_in_ready;
    assign fifo_in_valid = in_valid && sum_in_ready;
    assign sum_in_valid  = in_valid && fifo_in_ready;

    matrix_fifo #(.DEPTH(2 * GROUP_BEATS), .BEAT_T(sample_beat_t)) u_in_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_beat(in_beat), .in_valid(fifo_in_valid), .in_ready(fifo_in_ready),
        .out_beat(fifo_beat), .out_valid(fifo_out_valid), .out_ready(fifo_out_ready)
    );

    lane_reduce_acc #(
        .GROUP_BEATS(GROUP_BEATS), .WIDTH($bits(sample_t)),
        .OUT_WIDTH($bits(sum_t)), .SIGNED(1'b1)
    ) u_sum_acc (
        .clk(clk), .rst_n(rst_n),
        .lanes(in_beat.lane), .in_valid(sum_in_valid), .in_ready(sum_in_ready),
        .total(sum_total), .out_valid(sum_valid), .out_ready(sum_ready)
    );

    // Signed division truncates toward zero
    assign mean = sample_t'(sum_total / sum_t'(N));

    repeat_buffer #(.GROUP_BEATS(GROUP_BEATS), .WIDTH($bits(sample_t))) u_mean_rep (
        .clk(clk), .rst_n(rst_n),
        .in_data(mean), .in_valid(sum_valid), .in_ready(sum_ready),
        .out_data(mean_rep), .out_valid(mean_rep_valid), .out_ready(mean_rep_ready)
    );

    // Join buffered samples with the replayed mean
    assign cs_in_valid    = fifo_out_valid && mean_rep_valid;
    assign fifo_out_ready = cs_in_ready && mean_rep_valid;
    assign mean_rep_ready = cs_in_ready && fifo_out_valid;

    center_square u_center (
        .clk(clk), .rst_n(rst_n),
        .in_beat(fifo_beat), .mean(mean_rep), .in_valid(cs_in_valid), .in_ready(cs_in_ready),
        .diff_beat(cs_diff), .diff_valid(cs_diff_valid), .diff_ready(cs_diff_ready),
        .squares(cs_sq), .sq_valid(cs_sq_valid), .sq_ready(cs_sq_ready)
    );

    matrix_fifo #(.DEPTH(GROUP_BEATS), .BEAT_T(diff_beat_t)) u_diff_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_beat(cs_diff), .in_valid(cs_diff_valid), .in_ready(cs_diff_ready),
        .out_beat(dfifo_beat), .out_valid(dfifo_valid), .out_ready(dfifo_ready)
    );

    lane_reduce_acc #(
        .GROUP_BEATS(GROUP_BEATS), .WIDTH($bits(square_t)),
        .OUT_WIDTH($bits(sumsq_t)), .SIGNED(1'b0)
    ) u_sq_acc (
        .clk(clk), .rst_n(rst_n),
        .lanes(cs_sq), .in_valid(cs_sq_valid), .in_ready(cs_sq_ready),
        .total(sumsq), .out_valid(sumsq_valid), .out_ready(sumsq_ready)
    );

    inv_sqrt_unit #(.GROUP_BEATS(GROUP_BEATS)) u_isqrt (
        .clk(clk), .rst_n(rst_n),
        .sumsq(sumsq), .in_valid(sumsq_valid), .in_ready(sumsq_ready),
        .isqrt(isq), .out_valid(isq_valid), .out_ready(isq_ready)
    );

    repeat_buffer #(.GROUP_BEATS(GROUP_BEATS), .WIDTH($bits(isqrt_t))) u_isqrt_rep (
        .clk(clk), .rst_n(rst_n),
        .in_data(isq), .in_valid(isq_valid), .in_ready(isq_ready),
        .out_data(isq_rep), .out_valid(isq_rep_valid), .out_ready(isq_rep_ready)
    );

    // Join differences with the replayed scale
    assign nsc_in_valid  = dfifo_valid && isq_rep_valid;
    assign dfifo_ready   = nsc_in_ready && isq_rep_valid;
    assign isq_rep_ready = nsc_in_ready && dfifo_valid;

    norm_scale_cast u_scale (
        .clk(clk), .rst_n(rst_n),
        .diff_beat(dfifo_beat), .isqrt(isq_rep), .in_valid(nsc_in_valid), .in_ready(nsc_in_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// ==== bench/group_norm_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module group_norm_assert
    import norm_fixed_pkg::*;
#(
    parameter int GROUP_BEATS = 8
) (
    input logic         clk,
    input logic         rst_n,
    input sample_beat_t in_beat,
    input logic         in_valid,
    input logic         in_ready,
    input sample_beat_t out_beat,
    input logic         out_valid,
    input logic         out_ready
);

    int beats_in;
    int idle_fails = 0;
    int out_hold_fails = 0;
    int in_hold_fails = 0;
    int fail_count;

    assign fail_count = idle_fails + out_hold_fails + in_hold_fails;

    // Input beats accepted since reset up to one group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            beats_in <= 0;
        else if (in_valid && in_ready && beats_in < GROUP_BEATS)
            beats_in <= beats_in + 1;
    end

    // Nothing leaves before a whole group has entered
    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (beats_in < GROUP_BEATS) |-> !out_valid)
        else begin
            $error("out_valid rose before the first full group was accepted");
            idle_fails++;
        end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            $error("Output beat changed or dropped while stalled");
            out_hold_fails++;
        end

    // Driver side of the input handshake
    a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_beat))
        else begin
            $error("Input beat changed or dropped while stalled");
            in_hold_fails++;
        end

endmodule

bind group_norm_2d group_norm_assert #(.GROUP_BEATS(GROUP_BEATS)) u_protocol_chk (
    .clk(clk),
    .rst_n(rst_n),
    .in_beat(in_beat),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .out_beat(out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready)
);

`default_nettype wire

// ==== bench/group_norm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module group_norm_tb
    import norm_fixed_pkg::*;
();

    localparam int TOTAL_DIM0 = 4;
    localparam int TOTAL_DIM1 = 4;
    localparam int GROUP_CHANNELS = 2;
    localparam int GROUP_BEATS = TOTAL_DIM0 * TOTAL_DIM1 * GROUP_CHANNELS / LANES;
    localparam int N = GROUP_BEATS * LANES;
    localparam int MAX_GROUPS = 40;
    localparam int CYCLE_LIMIT = MAX_GROUPS * GROUP_BEATS * 4 + 200;

    localparam int KIND_CONST = 0;
    localparam int KIND_RANDOM = 1;
    localparam int KIND_SPREAD = 2;

    `include "isqrt_lut.svh"

    logic clk;
    logic rst_n;
    sample_beat_t in_beat;
    logic in_valid;
    logic in_ready;
    sample_beat_t out_beat;
    logic out_valid;
    logic out_ready;

    int seed = 98770;
    int errors = 0;
    int checked = 0;
    int tests_run = 0;
    int sat_lanes = 0;
    int cycles = 0;
    string test_name = "reset";
    logic gap_en;
    logic bp_en;
    sample_beat_t grp [GROUP_BEATS];
    sample_beat_t send_q [$];
    sample_beat_t exp_q [$];

    group_norm_2d #(
        .TOTAL_DIM0(TOTAL_DIM0),
        .TOTAL_DIM1(TOTAL_DIM1),
        .GROUP_CHANNELS(GROUP_CHANNELS)
    ) i_dut (
        .clk(clk),
        .rst_n(rst_n),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_beat(out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    always #10 clk = ~clk;

    function automatic int lane_val(input sample_beat_t bt, input int l);
        sample_t v;
        v = bt.lane[l];
        return int'(v);
    endfunction

    // Shift by two until the index fits the table and undo with k
    function automatic int isqrt_ref(input int var_in);
        int v;
        int k;
        v = var_in;
        k = 0;
        while (v >= LUT_ENTRIES) begin
            v = v >> 2;
            k++;
        end
        return int'(ISQRT_LUT[v]) >> k;
    endfunction

    function automatic sample_t scale_ref(input int d, input int s);
        int f;
        f = (d * s) >>> 12;
        if (f > 127)
            return sample_t'(127);
        if (f < -128)
            return sample_t'(-128);
        return sample_t'(f);
    endfunction

    function automatic int error_total();
        return errors + i_dut.u_protocol_chk.fail_count;
    endfunction

    task automatic fill_group(input int kind);
        sample_t base;
        int r;
        base = sample_t'($random(seed));
        for (int b = 0; b < GROUP_BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                r = $random(seed);
                case (kind)
                    KIND_CONST:  grp[b].lane[l] = base;
                    KIND_SPREAD: grp[b].lane[l] = ((r & 3) == 0) ? sample_t'(-128) : sample_t'(127);
                    default:     grp[b].lane[l] = sample_t'(r);
                endcase
            end
        end
    endtask

    // Reference model for one group that queues stimulus and expected beats
    task automatic queue_group();
        int sum;
        int mean;
        int sumsq;
        int d;
        int s;
        sample_beat_t exp_beat;
        sum = 0;
        sumsq = 0;
        for (int b = 0; b < GROUP_BEATS; b++)
            for (int l = 0; l < LANES; l++)
                sum += lane_val(grp[b], l);
        mean = sum / N;
        for (int b = 0; b < GROUP_BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                d = lane_val(grp[b], l) - mean;
                sumsq += d * d;
            end
        end
        s = isqrt_ref(sumsq / N);
        for (int b = 0; b < GROUP_BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                exp_beat.lane[l] = scale_ref(lane_val(grp[b], l) - mean, s);
                if (exp_beat.lane[l] == sample_t'(127) || exp_beat.lane[l] == sample_t'(-128))
                    sat_lanes++;
            end
            send_q.push_back(grp[b]);
            exp_q.push_back(exp_beat);
        end
    endtask

    task automatic run_test(input string name, input int kind, input int groups,
                            input logic gaps, input logic bp);
        int start_err;
        int start_checked;
        test_name = name;
        gap_en = gaps;
        bp_en = bp;
        sat_lanes = 0;
        start_err = error_total();
        start_checked = checked;
        for (int g = 0; g < groups; g++) begin
            fill_group(kind);
            queue_group();
        end
        while (exp_q.size() != 0)
            @(posedge clk);
        tests_run++;
        $display("%s: %0d groups, %0d beats checked, %0d saturated lanes expected, %s",
                 name, groups, checked - start_checked, sat_lanes,
                 (error_total() == start_err) ? "ok" : "FAILED");
    endtask

    // Input driver that holds a beat until it is taken
    always @(posedge clk) begin
        if (!rst_n) begin
            in_valid <= 1'b0;
        end else begin
            if (in_valid && in_ready)
                void'(send_q.pop_front());
            if (in_valid && !in_ready) begin
            end else if (send_q.size() > 0 && (!gap_en || ($random(seed) & 1) == 1)) begin
                in_valid <= 1'b1;
                in_beat  <= send_q[0];
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n)
            out_ready <= 1'b0;
        else if (bp_en)
            out_ready <= (($random(seed) & 1) == 1);
        else
            out_ready <= 1'b1;
    end

    always @(posedge clk) begin : check_out
        sample_beat_t exp_beat;
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output beat %h arrived with nothing expected in %s", out_beat, test_name);
                errors++;
            end else begin
                exp_beat = exp_q.pop_front();
                checked++;
                assert (out_beat == exp_beat) else begin
                    $display("Mismatch in %s: expected %h, actual %h", test_name, exp_beat, out_beat);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in %s with %0d beats still expected",
                     cycles, test_name, exp_q.size());
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        in_beat = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        gap_en = 1'b0;
        bp_en = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        run_test("constant", KIND_CONST, 2, 1'b0, 1'b0);
        run_test("random", KIND_RANDOM, 10, 1'b1, 1'b0);
        run_test("saturate", KIND_SPREAD, 4, 1'b1, 1'b0);
        run_test("back_to_back", KIND_RANDOM, 8, 1'b0, 1'b0);
        run_test("backpressure", KIND_RANDOM, 8, 1'b1, 1'b1);
        $display("Tests: %0d, beats checked: %0d, errors: %0d", tests_run, checked, error_total());
        if (error_total() == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
design/norm_fixed_pkg.sv
design/norm_ctrl_pkg.sv
design/matrix_fifo.sv
design/lane_reduce_acc.sv
design/repeat_buffer.sv
design/center_square.sv
design/inv_sqrt_unit.sv
design/norm_scale_cast.sv
design/group_norm_2d.sv
bench/group_norm_assert.sv
bench/group_norm_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= group_norm_tb
LOG       ?= sim.log
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
